//--- hdl/scaler_pkg.sv
package scaler_pkg;

    localparam int PIXEL_WIDTH      = 12;
    localparam int MAX_LINE_SIZE    = 1024;
    localparam int ADDR_WIDTH       = $clog2(MAX_LINE_SIZE);
    localparam int NUM_LINE_BUFFERS = 5;
    localparam int LINE_STEP        = 4096;     // One input line in 4.12
    localparam int COEFF_WIDTH      = 10;       // 512 is unity gain
    localparam int PHASE_WIDTH      = 10;
    localparam int SPARSE_OUTPUT    = 2;        // Idle cycles between output pixels
    localparam int POS_WIDTH        = 24;
    localparam int PROD_WIDTH       = COEFF_WIDTH + PIXEL_WIDTH;
    localparam int SUM_WIDTH        = COEFF_WIDTH + PIXEL_WIDTH + 2;

    localparam logic signed [SUM_WIDTH-1:0] ROUND_BIAS = 128;

    typedef logic [PIXEL_WIDTH-1:0] pixel_t;
    typedef logic [COEFF_WIDTH-1:0] coeff_t;
    typedef logic [PHASE_WIDTH-1:0] phase_t;
    typedef logic [2:0]             buf_sel_t;

    // Catmull-Rom weight magnitude, outer taps 0 and 3 are subtracted
    function automatic coeff_t cubic_coeff(input phase_t phase, input int tap);
        longint unit;
        longint p;
        longint y;
        longint w0;
        longint w1;
        longint w3;
        longint w;
        int     shift;
        unit  = longint'(1) << PHASE_WIDTH;
        p     = longint'(phase);
        y     = unit - p;
        shift = 3 * PHASE_WIDTH + 1 - (COEFF_WIDTH - 1);
        w0 = (p * y * y + (longint'(1) << (shift - 1))) >>> shift;
        w1 = (3 * p * p * p - 5 * p * p * unit + 2 * unit * unit * unit
              + (longint'(1) << (shift - 1))) >>> shift;
        w3 = (p * p * y + (longint'(1) << (shift - 1))) >>> shift;
        case (tap)
            0:       w = w0;
            1:       w = w1;
            2:       w = (longint'(1) << (COEFF_WIDTH - 1)) - w1 + w0 + w3;  // Exact unity sum
            default: w = w3;
        endcase
        return coeff_t'(w);
    endfunction

endpackage

//--- hdl/line_store.sv
`timescale 1ns/1ps

module line_store (
    input  logic                              clk,
    input  logic                              arst_n,
    input  scaler_pkg::pixel_t                d_in,
    input  logic                              dv_in,
    input  logic                              hs_in,
    input  logic                              vs_in,
    input  logic [scaler_pkg::ADDR_WIDTH-1:0] rd_addr,
    output scaler_pkg::pixel_t                rd_q0,
    output scaler_pkg::pixel_t                rd_q1,
    output scaler_pkg::pixel_t                rd_q2,
    output scaler_pkg::pixel_t                rd_q3,
    output scaler_pkg::pixel_t                rd_q4,
    output scaler_pkg::buf_sel_t              wr_sel,
    output logic [scaler_pkg::POS_WIDTH-1:0]  in_pos
);
    import scaler_pkg::*;

    logic [ADDR_WIDTH:0] wr_addr;   // Spare bit catches overlong lines

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_addr <= '0;
            wr_sel  <= '0;
            in_pos  <= '0;
        end else if (dv_in) begin
            wr_addr <= wr_addr + 1'b1;
            if (hs_in) begin
                wr_addr <= '0;
                in_pos  <= in_pos + POS_WIDTH'(LINE_STEP);
                if (wr_sel == buf_sel_t'(NUM_LINE_BUFFERS - 1)) begin
                    wr_sel <= '0;
                end else begin
                    wr_sel <= wr_sel + 1'b1;
                end
            end
            // Frame end restarts the rotation
            if (vs_in) begin
                wr_addr <= '0;
                wr_sel  <= '0;
                in_pos  <= '0;
            end
        end
    end

    for (genvar b = 0; b < NUM_LINE_BUFFERS; b++) begin : g_buf
        pixel_t mem [MAX_LINE_SIZE];
        pixel_t q;

        always_ff @(posedge clk) begin
            if (dv_in && wr_sel == buf_sel_t'(b)) begin
                mem[wr_addr[ADDR_WIDTH-1:0]] <= d_in;
            end
            q <= mem[rd_addr];      // All five read in parallel
        end
    end

    assign rd_q0 = g_buf[0].q;
    assign rd_q1 = g_buf[1].q;
    assign rd_q2 = g_buf[2].q;
    assign rd_q3 = g_buf[3].q;
    assign rd_q4 = g_buf[4].q;

    // Input line must fit one buffer
    a_wr_addr_range: assert property (
        @(posedge clk) disable iff (!arst_n)
        dv_in |-> wr_addr < MAX_LINE_SIZE
    );

endmodule

//--- hdl/cubic_table.sv
`timescale 1ns/1ps

module cubic_table (
    input  logic               clk,
    input  scaler_pkg::phase_t phase,
    output scaler_pkg::coeff_t f0,
    output scaler_pkg::coeff_t f1,
    output scaler_pkg::coeff_t f2,
    output scaler_pkg::coeff_t f3
);
    import scaler_pkg::*;

    logic [4*COEFF_WIDTH-1:0] rom [2**PHASE_WIDTH];
    logic [4*COEFF_WIDTH-1:0] word;

    // Constant table, one entry of four weights per phase
    for (genvar p = 0; p < 2**PHASE_WIDTH; p++) begin : g_rom
        assign rom[p] = {
            cubic_coeff(phase_t'(p), 3),
            cubic_coeff(phase_t'(p), 2),
            cubic_coeff(phase_t'(p), 1),
            cubic_coeff(phase_t'(p), 0)
        };
    end

    always_ff @(posedge clk) begin
        word <= rom[phase];
    end

    assign f0 = word[0*COEFF_WIDTH +: COEFF_WIDTH];
    assign f1 = word[1*COEFF_WIDTH +: COEFF_WIDTH];
    assign f2 = word[2*COEFF_WIDTH +: COEFF_WIDTH];
    assign f3 = word[3*COEFF_WIDTH +: COEFF_WIDTH];

endmodule

//--- hdl/line_sequencer.sv
`timescale 1ns/1ps

module line_sequencer (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic [15:0]                       vertical_scale_step,
    input  logic [15:0]                       vertical_scale_line_size,
    input  logic                              dv_in,
    input  logic                              vs_in,
    input  logic [scaler_pkg::POS_WIDTH-1:0]  in_pos,
    output logic [scaler_pkg::ADDR_WIDTH-1:0] rd_addr,
    output scaler_pkg::phase_t                phase,
    output logic                              rd_strobe,
    output logic                              line_first,
    output logic                              frame_first
);
    import scaler_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SETUP,
        ST_GEN
    } state_t;

    state_t               state;
    logic [3:0]           sparse_cnt;
    logic [POS_WIDTH-1:0] out_pos;      // 4.12 output line position
    logic                 last_step;

    assign last_step   = rd_strobe && (16'(rd_addr) == vertical_scale_line_size);
    assign line_first  = rd_strobe && (rd_addr == '0);
    assign frame_first = line_first && (out_pos == POS_WIDTH'(2 * LINE_STEP));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= ST_IDLE;
            sparse_cnt <= '0;
            out_pos    <= '0;
            rd_addr    <= '0;
            phase      <= '0;
            rd_strobe  <= 1'b0;
        end else begin
            rd_strobe <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (in_pos > out_pos) begin
                        phase <= out_pos[PHASE_WIDTH+1:2];
                        state <= ST_SETUP;
                    end
                end
                ST_SETUP: begin     // Coefficient lookup
                    rd_addr    <= '0;
                    sparse_cnt <= '0;
                    state      <= ST_GEN;
                end
                ST_GEN: begin
                    if (sparse_cnt == SPARSE_OUTPUT && !last_step) begin
                        sparse_cnt <= '0;
                        rd_strobe  <= 1'b1;
                    end else begin
                        sparse_cnt <= sparse_cnt + 1'b1;
                    end
                    // Address moves on once its strobe has gone out
                    if (last_step) begin
                        out_pos <= out_pos + POS_WIDTH'(vertical_scale_step);
                        state   <= ST_IDLE;
                    end else if (rd_strobe) begin
                        rd_addr <= rd_addr + 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
            if (dv_in && vs_in) begin
                out_pos <= POS_WIDTH'(2 * LINE_STEP);   // First output sits on line 2
            end
        end
    end

    a_state_legal: assert property (
        @(posedge clk) disable iff (!arst_n)
        state inside {ST_IDLE, ST_SETUP, ST_GEN}
    );

    a_rd_addr_range: assert property (
        @(posedge clk) disable iff (!arst_n)
        state == ST_GEN |-> 16'(rd_addr) <= vertical_scale_line_size
    );

endmodule

//--- hdl/vertical_filter.sv
`timescale 1ns/1ps

module vertical_filter (
    input  logic                                    clk,
    input  logic                                    arst_n,
    input  scaler_pkg::pixel_t                      rd_q0,
    input  scaler_pkg::pixel_t                      rd_q1,
    input  scaler_pkg::pixel_t                      rd_q2,
    input  scaler_pkg::pixel_t                      rd_q3,
    input  scaler_pkg::pixel_t                      rd_q4,
    input  scaler_pkg::buf_sel_t                    wr_sel,
    input  logic [scaler_pkg::POS_WIDTH-1:0]        in_pos,
    input  scaler_pkg::coeff_t                      f0,
    input  scaler_pkg::coeff_t                      f1,
    input  scaler_pkg::coeff_t                      f2,
    input  scaler_pkg::coeff_t                      f3,
    output logic signed [scaler_pkg::SUM_WIDTH-1:0] sum
);
    import scaler_pkg::*;

    pixel_t                q    [NUM_LINE_BUFFERS];
    coeff_t                f    [4];
    pixel_t                tap  [4];
    logic [PROD_WIDTH-1:0] prod [4];

    assign q[0] = rd_q0;
    assign q[1] = rd_q1;
    assign q[2] = rd_q2;
    assign q[3] = rd_q3;
    assign q[4] = rd_q4;

    assign f[0] = f0;
    assign f[1] = f1;
    assign f[2] = f2;
    assign f[3] = f3;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int k = 0; k < 4; k++) begin
                tap[k]  <= '0;
                prod[k] <= '0;
            end
            sum <= '0;
        end else begin
            for (int k = 0; k < 4; k++) begin
                // Newest complete line sits just behind the write buffer
                tap[k]  <= q[(int'(wr_sel) + NUM_LINE_BUFFERS - 1 - k) % NUM_LINE_BUFFERS];
                prod[k] <= f[k] * tap[k];
            end
            if (in_pos < POS_WIDTH'(4 * LINE_STEP)) begin
                tap[3] <= '0;       // Oldest buffer not yet filled
            end
            sum <= $signed({2'b00, prod[1]}) + $signed({2'b00, prod[2]})
                 - $signed({2'b00, prod[0]}) - $signed({2'b00, prod[3]})
                 + ROUND_BIAS;
        end
    end

endmodule

//--- hdl/pixel_output.sv
`timescale 1ns/1ps

module pixel_output (
    input  logic                                    clk,
    input  logic                                    arst_n,
    input  logic signed [scaler_pkg::SUM_WIDTH-1:0] sum,
    input  logic                                    rd_strobe,
    input  logic                                    line_first,
    input  logic                                    frame_first,
    output scaler_pkg::pixel_t                      d_out,
    output logic                                    dv_out,
    output logic                                    hs_out,
    output logic                                    vs_out
);
    import scaler_pkg::*;

    logic [3:0] dv_dly;
    logic [3:0] hs_dly;
    logic [3:0] vs_dly;

    always_ff @(posedge clk) begin
        if (sum[SUM_WIDTH-1]) begin
            d_out <= '0;                                // Undershoot
        end else if (|sum[SUM_WIDTH-2:PROD_WIDTH-1]) begin
            d_out <= '1;                                // Overshoot
        end else begin
            d_out <= sum[COEFF_WIDTH-1 +: PIXEL_WIDTH];
        end
    end

    // Match the read, tap, multiply and sum stages
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dv_dly <= '0;
            hs_dly <= '0;
            vs_dly <= '0;
            dv_out <= 1'b0;
            hs_out <= 1'b0;
            vs_out <= 1'b0;
        end else begin
            dv_dly <= {dv_dly[2:0], rd_strobe};
            hs_dly <= {hs_dly[2:0], line_first};
            vs_dly <= {vs_dly[2:0], frame_first};
            dv_out <= dv_dly[3];
            hs_out <= hs_dly[3] & dv_dly[3];
            vs_out <= vs_dly[3] & dv_dly[3];
        end
    end

    a_sync_with_dv: assert property (
        @(posedge clk) disable iff (!arst_n)
        (hs_out || vs_out) |-> dv_out
    );

endmodule

//--- hdl/scaler_vertical.sv
`timescale 1ns/1ps

module scaler_vertical (
    input  logic               clk,
    input  logic               arst_n,
    input  logic [15:0]        vertical_scale_step,        // 4.12, 4096 is unity
    input  logic [15:0]        vertical_scale_line_size,   // Last pixel index of a line
    input  scaler_pkg::pixel_t d_in,
    input  logic               dv_in,
    input  logic               hs_in,
    input  logic               vs_in,
    output scaler_pkg::pixel_t d_out,
    output logic               dv_out,
    output logic               hs_out,
    output logic               vs_out
);
    import scaler_pkg::*;

    logic [ADDR_WIDTH-1:0]       rd_addr;
    phase_t                      phase;
    logic                        rd_strobe;
    logic                        line_first;
    logic                        frame_first;
    pixel_t                      rd_q0;
    pixel_t                      rd_q1;
    pixel_t                      rd_q2;
    pixel_t                      rd_q3;
    pixel_t                      rd_q4;
    buf_sel_t                    wr_sel;
    logic [POS_WIDTH-1:0]        in_pos;
    coeff_t                      f0;
    coeff_t                      f1;
    coeff_t                      f2;
    coeff_t                      f3;
    logic signed [SUM_WIDTH-1:0] sum;

    line_store u_line_store (
        .clk     (clk),
        .arst_n  (arst_n),
        .d_in    (d_in),
        .dv_in   (dv_in),
        .hs_in   (hs_in),
        .vs_in   (vs_in),
        .rd_addr (rd_addr),
        .rd_q0   (rd_q0),
        .rd_q1   (rd_q1),
        .rd_q2   (rd_q2),
        .rd_q3   (rd_q3),
        .rd_q4   (rd_q4),
        .wr_sel  (wr_sel),
        .in_pos  (in_pos)
    );

    line_sequencer u_line_sequencer (
        .clk                      (clk),
        .arst_n                   (arst_n),
        .vertical_scale_step      (vertical_scale_step),
        .vertical_scale_line_size (vertical_scale_line_size),
        .dv_in                    (dv_in),
        .vs_in                    (vs_in),
        .in_pos                   (in_pos),
        .rd_addr                  (rd_addr),
        .phase                    (phase),
        .rd_strobe                (rd_strobe),
        .line_first               (line_first),
        .frame_first              (frame_first)
    );

    cubic_table u_cubic_table (
        .clk   (clk),
        .phase (phase),
        .f0    (f0),
        .f1    (f1),
        .f2    (f2),
        .f3    (f3)
    );

    vertical_filter u_vertical_filter (
        .clk    (clk),
        .arst_n (arst_n),
        .rd_q0  (rd_q0),
        .rd_q1  (rd_q1),
        .rd_q2  (rd_q2),
        .rd_q3  (rd_q3),
        .rd_q4  (rd_q4),
        .wr_sel (wr_sel),
        .in_pos (in_pos),
        .f0     (f0),
        .f1     (f1),
        .f2     (f2),
        .f3     (f3),
        .sum    (sum)
    );

    pixel_output u_pixel_output (
        .clk         (clk),
        .arst_n      (arst_n),
        .sum         (sum),
        .rd_strobe   (rd_strobe),
        .line_first  (line_first),
        .frame_first (frame_first),
        .d_out       (d_out),
        .dv_out      (dv_out),
        .hs_out      (hs_out),
        .vs_out      (vs_out)
    );

endmodule

//--- verif/tb_scaler_vertical.sv
`timescale 1ns/1ps

module tb_scaler_vertical;
    import scaler_pkg::*;

    localparam int LINE_SIZE  = 15;     // Last pixel index of a line
    localparam int NUM_LINES  = 10;
    localparam int NUM_FRAMES = 4;
    localparam int PIX_MAX    = (1 << PIXEL_WIDTH) - 1;
    localparam int MODE_MODEL = 0;
    localparam int MODE_COPY  = 1;
    localparam int MODE_CONST = 2;
    // Frames times lines times pixel slots plus room for reset and idle checks
    localparam int WATCHDOG_CYCLES =
        NUM_FRAMES * NUM_LINES * (LINE_SIZE + 1) * (SPARSE_OUTPUT + 1) * 4 + 1000;

    logic        clk;
    logic        arst_n;
    logic [15:0] vertical_scale_step;
    logic [15:0] vertical_scale_line_size;
    pixel_t      d_in;
    logic        dv_in;
    logic        hs_in;
    logic        vs_in;
    pixel_t      d_out;
    logic        dv_out;
    logic        hs_out;
    logic        vs_out;

    logic [31:0] rng_state = 32'hf0cc;
    int          img [NUM_LINES][LINE_SIZE+1];
    pixel_t      exp_pix [$];
    logic        exp_hs [$];
    logic        exp_vs [$];
    int          exp_lines;
    int          lines_seen;

    scaler_vertical dut (
        .clk                      (clk),
        .arst_n                   (arst_n),
        .vertical_scale_step      (vertical_scale_step),
        .vertical_scale_line_size (vertical_scale_line_size),
        .d_in                     (d_in),
        .dv_in                    (dv_in),
        .hs_in                    (hs_in),
        .vs_in                    (vs_in),
        .d_out                    (d_out),
        .dv_out                   (dv_out),
        .hs_out                   (hs_out),
        .vs_out                   (vs_out)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_pixel(input string name, input pixel_t got, input pixel_t want);
        if (got !== want) begin
            abort_run($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, want));
        end
    endtask

    task automatic check_strobe(input string name, input logic got, input logic want);
        if (got !== want) begin
            abort_run($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, want));
        end
    endtask

    task automatic check_count(input string name, input int got, input int want);
        if (got != want) begin
            abort_run($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, want));
        end
    endtask

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // Four newest complete lines, Catmull-Rom weights, rounding and clamp
    function automatic pixel_t model_pixel(input int pos, input int x);
        phase_t ph;
        int     j;
        longint m [4];
        longint s;
        ph = phase_t'(pos >> 2);        // Fraction bits 11:2
        j  = pos / LINE_STEP;           // Newest complete line
        for (int k = 0; k < 3; k++) begin
            m[k] = img[j - k][x];
        end
        if (j < 3) begin
            m[3] = 0;
        end else begin
            m[3] = img[j - 3][x];
        end
        s = longint'(cubic_coeff(ph, 1)) * m[1] + longint'(cubic_coeff(ph, 2)) * m[2]
          - longint'(cubic_coeff(ph, 0)) * m[0] - longint'(cubic_coeff(ph, 3)) * m[3]
          + 128;
        if (s < 0) begin
            return '0;
        end
        s = s >>> (COEFF_WIDTH - 1);
        if (s > PIX_MAX) begin
            return pixel_t'(PIX_MAX);
        end
        return pixel_t'(s);
    endfunction

    task automatic build_expected(input int step, input int mode, input int cval);
        int     pos;
        int     j;
        pixel_t v;
        pos       = 2 * LINE_STEP;
        exp_lines = 0;
        // Last line closes the frame without adding to the input position
        while (pos < (NUM_LINES - 1) * LINE_STEP) begin
            j = pos / LINE_STEP;
            for (int x = 0; x <= LINE_SIZE; x++) begin
                if (mode == MODE_COPY) begin
                    v = pixel_t'(img[j - 1][x]);    // Phase 0 passes tap 1 through
                end else if (mode == MODE_CONST && j >= 3) begin
                    v = pixel_t'(cval);
                end else begin
                    v = model_pixel(pos, x);
                end
                exp_pix.push_back(v);
                exp_hs.push_back(x == 0);
                exp_vs.push_back(x == 0 && pos == 2 * LINE_STEP);
            end
            exp_lines++;
            pos += step;
        end
    endtask

    task automatic drive_frame(input int step);
        int blank;
        blank = ((LINE_SIZE + 1) * (SPARSE_OUTPUT + 1) + 8)
              * ((LINE_STEP + step - 1) / step) + 8;
        for (int y = 0; y < NUM_LINES; y++) begin
            for (int x = 0; x <= LINE_SIZE; x++) begin
                @(negedge clk);
                d_in  = pixel_t'(img[y][x]);
                dv_in = 1'b1;
                hs_in = (x == LINE_SIZE);
                vs_in = (x == LINE_SIZE) && (y == NUM_LINES - 1);
            end
            @(negedge clk);
            dv_in = 1'b0;
            hs_in = 1'b0;
            vs_in = 1'b0;
            repeat (blank) @(negedge clk);  // Blanking for every output line
        end
    endtask

    task automatic run_frame(input int step, input int mode, input int cval);
        @(negedge clk);
        vertical_scale_step = 16'(step);
        lines_seen = 0;
        build_expected(step, mode, cval);
        drive_frame(step);
        // Last output line starts before the closing input line arrives
        check_count("output lines per frame", lines_seen, exp_lines);
        while (exp_pix.size() != 0) begin
            @(negedge clk);
        end
    endtask

    // Single pixel frame end puts the output position on line 2
    task automatic send_frame_sync();
        @(negedge clk);
        d_in  = '0;
        dv_in = 1'b1;
        hs_in = 1'b1;
        vs_in = 1'b1;
        @(negedge clk);
        dv_in = 1'b0;
        hs_in = 1'b0;
        vs_in = 1'b0;
        repeat (4) @(negedge clk);
    endtask

    task automatic test_idle_after_reset();
        repeat (50) begin
            @(negedge clk);
            check_strobe("dv_out", dv_out, 1'b0);
            check_strobe("hs_out", hs_out, 1'b0);
            check_strobe("vs_out", vs_out, 1'b0);
        end
    endtask

    task automatic test_unity_step();
        for (int y = 0; y < NUM_LINES; y++) begin
            for (int x = 0; x <= LINE_SIZE; x++) begin
                img[y][x] = int'(lcg_next() >> 20);
            end
        end
        run_frame(LINE_STEP, MODE_COPY, 0);
    endtask

    task automatic test_constant_frame();
        int c;
        c = 2731;
        for (int y = 0; y < NUM_LINES; y++) begin
            for (int x = 0; x <= LINE_SIZE; x++) begin
                img[y][x] = c;
            end
        end
        run_frame(2048, MODE_CONST, c);
        run_frame(6144, MODE_CONST, c);
    endtask

    task automatic test_random_edge();
        for (int y = 0; y < NUM_LINES; y++) begin
            for (int x = 0; x <= LINE_SIZE; x++) begin
                if (x < 4) begin
                    img[y][x] = (y < 5) ? 0 : PIX_MAX;      // Rising edge with overshoot
                end else if (x < 8) begin
                    img[y][x] = (y < 5) ? PIX_MAX : 0;      // Falling edge with undershoot
                end else begin
                    img[y][x] = int'(lcg_next() >> 20);
                end
            end
        end
        run_frame(3000, MODE_MODEL, 0);
    endtask

    initial begin : output_monitor
        int     cycle;
        int     last_dv;
        pixel_t want_pix;
        logic   want_hs;
        logic   want_vs;
        cycle   = 0;
        last_dv = 0;
        forever begin
            @(negedge clk);
            cycle++;
            if (dv_out) begin
                if (exp_pix.size() == 0) begin
                    abort_run("dv_out pulsed when no output pixel was expected");
                end else begin
                    want_pix = exp_pix.pop_front();
                    want_hs  = exp_hs.pop_front();
                    want_vs  = exp_vs.pop_front();
                    check_pixel("d_out", d_out, want_pix);
                    check_strobe("hs_out", hs_out, want_hs);
                    check_strobe("vs_out", vs_out, want_vs);
                    if (hs_out) begin
                        lines_seen++;
                    end else begin
                        check_count("dv_out spacing", cycle - last_dv, SPARSE_OUTPUT + 1);
                    end
                    last_dv = cycle;
                end
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        abort_run($sformatf("Timeout, run still going after %0d clock cycles",
                            WATCHDOG_CYCLES));
    end

    initial begin
        arst_n                   = 1'b0;
        d_in                     = '0;
        dv_in                    = 1'b0;
        hs_in                    = 1'b0;
        vs_in                    = 1'b0;
        vertical_scale_step      = 16'(LINE_STEP);
        vertical_scale_line_size = 16'(LINE_SIZE);
        repeat (10) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        test_idle_after_reset();
        send_frame_sync();
        test_unity_step();
        test_constant_frame();
        test_random_edge();
        $display("Simulation PASSED");
        $finish;
    end

endmodule

//--- scaler_vertical.f
hdl/scaler_pkg.sv
hdl/line_store.sv
hdl/cubic_table.sv
hdl/line_sequencer.sv
hdl/vertical_filter.sv
hdl/pixel_output.sv
hdl/scaler_vertical.sv
verif/tb_scaler_vertical.sv

//--- Makefile
SIM      := verilator
TOP      := tb_scaler_vertical
FILELIST := scaler_vertical.f
OBJ_DIR  := obj_dir
FLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP) --Mdir $(OBJ_DIR)

.PHONY: sim clean

# A $fatal in the testbench gives a non-zero exit status
sim:
	$(SIM) $(FLAGS) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
